/* source/mem_subsys_config.svh */
`ifndef MEM_SUBSYS_CONFIG_SVH
`define MEM_SUBSYS_CONFIG_SVH

// Memory port widths
`define MS_ADDR_W 32
`define MS_DATA_W 32
`define MS_STRB_W 4

// Prefetch count field
`define MS_PF_CNT_W 4

// Load, store and prefetcher
`define MS_NUM_SRC 3

`endif

/* source/mem_subsys_pkg.sv */
`include "mem_subsys_config.svh"

package mem_subsys_pkg;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } mem_op_e;

  // Requester identity, also the arbiter port index
  typedef enum logic [1:0] {
    SRC_LOAD,
    SRC_STORE,
    SRC_PF
  } src_e;

  typedef struct packed {
    mem_op_e                 op;
    logic [`MS_ADDR_W-1:0]   addr;
    logic [`MS_DATA_W-1:0]   wdata;
    logic [`MS_STRB_W-1:0]   wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [`MS_DATA_W-1:0] rdata;
    logic                  err;
  } mem_rsp_t;

  // Master to slave
  typedef struct packed {
    logic                  aw_valid;
    logic [`MS_ADDR_W-1:0] aw_addr;
    logic                  w_valid;
    logic [`MS_DATA_W-1:0] w_data;
    logic [`MS_STRB_W-1:0] w_strb;
    logic                  b_ready;
    logic                  ar_valid;
    logic [`MS_ADDR_W-1:0] ar_addr;
    logic                  r_ready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    logic [1:0]            b_resp;
    logic                  ar_ready;
    logic                  r_valid;
    logic [`MS_DATA_W-1:0] r_data;
    logic [1:0]            r_resp;
  } axil_rsp_t;

  typedef struct packed {
    logic [`MS_ADDR_W-1:0]   base;
    logic [`MS_ADDR_W-1:0]   stride;
    logic [`MS_PF_CNT_W-1:0] count;
  } pf_cfg_t;

  typedef enum logic [1:0] {
    PF_IDLE,
    PF_ARMED,
    PF_RUN
  } pf_state_e;

  typedef enum logic [1:0] {
    AX_IDLE,
    AX_WRITE,
    AX_READ,
    AX_RESP
  } axil_state_e;

endpackage

/* source/core_port_adapter.sv */
`timescale 1ns/1ns

module core_port_adapter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Core side
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mem_subsys_pkg::mem_req_t req_i,
  output logic                    rsp_valid_o,
  output mem_subsys_pkg::mem_rsp_t rsp_o,
  // Arbiter side
  output logic                    arb_valid_o,
  output mem_subsys_pkg::mem_req_t arb_req_o,
  input  logic                    arb_grant_i,
  input  logic                    arb_rsp_valid_i,
  input  mem_subsys_pkg::mem_rsp_t arb_rsp_i
);

  import mem_subsys_pkg::*;

  logic     full_q;
  logic     granted_q;
  mem_req_t req_q;

  // One request per port, held until its response
  assign req_ready_o = !full_q;
  assign arb_valid_o = full_q && !granted_q;
  assign arb_req_o   = req_q;

  assign rsp_valid_o = arb_rsp_valid_i && granted_q;
  assign rsp_o       = arb_rsp_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q    <= 1'b0;
      granted_q <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        full_q <= 1'b1;
      end
      if (arb_grant_i) begin
        granted_q <= 1'b1;
      end
      // Port frees up with the response pulse
      if (rsp_valid_o) begin
        full_q    <= 1'b0;
        granted_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

endmodule

/* source/stride_prefetcher.sv */
`timescale 1ns/1ns
`include "mem_subsys_config.svh"

module stride_prefetcher (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Configuration
  input  logic                     cfg_set_i,
  input  mem_subsys_pkg::pf_cfg_t  cfg_i,
  output mem_subsys_pkg::pf_cfg_t  cfg_o,
  // Accepted loads
  input  logic                     snoop_valid_i,
  input  logic [`MS_ADDR_W-1:0]    snoop_addr_i,
  // Arbiter side
  output logic                     arb_valid_o,
  output mem_subsys_pkg::mem_req_t arb_req_o,
  input  logic                     arb_grant_i,
  input  logic                     arb_rsp_valid_i,
  // Status
  output logic                     busy_o,
  output logic [7:0]               issued_o
);

  import mem_subsys_pkg::*;

  pf_state_e               state_q;
  pf_cfg_t                 cfg_q;
  logic [`MS_ADDR_W-1:0]   addr_q;
  logic [`MS_PF_CNT_W-1:0] remain_q;
  logic                    valid_q;
  logic [7:0]              issued_q;
  logic                    trigger;

  assign trigger = (state_q == PF_ARMED) && snoop_valid_i &&
                   (snoop_addr_i == cfg_q.base) && (cfg_q.count != '0);

  assign cfg_o       = cfg_q;
  assign busy_o      = (state_q == PF_RUN);
  assign issued_o    = issued_q;
  assign arb_valid_o = valid_q;

  // Prefetches are plain reads, data is dropped
  assign arb_req_o.op    = OP_READ;
  assign arb_req_o.addr  = addr_q;
  assign arb_req_o.wdata = '0;
  assign arb_req_o.wstrb = '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= PF_IDLE;
      cfg_q    <= '0;
      addr_q   <= '0;
      remain_q <= '0;
      valid_q  <= 1'b0;
      issued_q <= '0;
    end else begin
      if (arb_grant_i) begin
        valid_q <= 1'b0;
      end
      if (arb_rsp_valid_i) begin
        issued_q <= issued_q + 8'd1;
      end
      if (cfg_set_i) begin
        cfg_q   <= cfg_i;
        state_q <= PF_ARMED;
        valid_q <= 1'b0;
      end else begin
        case (state_q)
          PF_ARMED: begin
            if (trigger) begin
              state_q  <= PF_RUN;
              addr_q   <= cfg_q.base + cfg_q.stride;
              remain_q <= cfg_q.count;
              valid_q  <= 1'b1;
            end
          end
          PF_RUN: begin
            // Next step only after the previous read returns
            if (arb_rsp_valid_i) begin
              if (remain_q == `MS_PF_CNT_W'(1)) begin
                state_q <= PF_ARMED;
              end else begin
                addr_q   <= addr_q + cfg_q.stride;
                remain_q <= remain_q - `MS_PF_CNT_W'(1);
                valid_q  <= 1'b1;
              end
            end
          end
          default: begin
            state_q <= state_q;
          end
        endcase
      end
    end
  end

endmodule

/* source/req_arbiter.sv */
`timescale 1ns/1ns
`include "mem_subsys_config.svh"

module req_arbiter (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Requesters
  input  logic [`MS_NUM_SRC-1:0]                          src_valid_i,
  input  mem_subsys_pkg::mem_req_t [`MS_NUM_SRC-1:0]      src_req_i,
  output logic [`MS_NUM_SRC-1:0]                          src_grant_o,
  output logic [`MS_NUM_SRC-1:0]                          src_rsp_valid_o,
  output mem_subsys_pkg::mem_rsp_t                        src_rsp_o,
  // Master side
  output logic                                            mst_valid_o,
  output mem_subsys_pkg::mem_req_t                        mst_req_o,
  input  logic                                            mst_accept_i,
  input  logic                                            mst_done_i,
  input  mem_subsys_pkg::mem_rsp_t                        mst_rsp_i
);

  import mem_subsys_pkg::*;

  logic busy_q;
  src_e last_q;
  src_e owner_q;
  src_e sel;
  logic take;

  // Round-robin search starting after the last grant
  always_comb begin : rr_pick
    int   idx;
    logic found;
    sel   = last_q;
    found = 1'b0;
    for (int k = 1; k <= `MS_NUM_SRC; k++) begin
      idx = (int'(last_q) + k) % `MS_NUM_SRC;
      if (!found && src_valid_i[idx]) begin
        found = 1'b1;
        sel   = src_e'(idx);
      end
    end
  end

  // Single transaction in flight
  assign mst_valid_o = !busy_q && (|src_valid_i);
  assign mst_req_o   = src_req_i[sel];
  assign take        = mst_valid_o && mst_accept_i;

  always_comb begin
    src_grant_o = '0;
    if (take) begin
      src_grant_o[sel] = 1'b1;
    end
    src_rsp_valid_o = '0;
    if (mst_done_i) begin
      src_rsp_valid_o[owner_q] = 1'b1;
    end
  end

  assign src_rsp_o = mst_rsp_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      last_q  <= SRC_PF;
      owner_q <= SRC_LOAD;
    end else begin
      if (take) begin
        busy_q  <= 1'b1;
        last_q  <= sel;
        owner_q <= sel;
      end else if (mst_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

/* source/axil_master.sv */
`timescale 1ns/1ns

module axil_master (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Request from the arbiter
  input  logic                      req_valid_i,
  input  mem_subsys_pkg::mem_req_t  req_i,
  output logic                      accept_o,
  output logic                      done_o,
  output mem_subsys_pkg::mem_rsp_t  rsp_o,
  // AXI4-Lite port
  output mem_subsys_pkg::axil_req_t axil_o,
  input  mem_subsys_pkg::axil_rsp_t axil_i
);

  import mem_subsys_pkg::*;

  axil_state_e state_q;
  mem_req_t    req_q;
  mem_rsp_t    rsp_q;
  logic        aw_done_q;
  logic        w_done_q;
  logic        ar_done_q;
  logic        done_q;
  logic        aw_hs;
  logic        w_hs;
  logic        b_hs;
  logic        ar_hs;
  logic        r_hs;

  assign accept_o = (state_q == AX_IDLE) && req_valid_i;
  assign done_o   = done_q;
  assign rsp_o    = rsp_q;

  always_comb begin
    axil_o          = '0;
    // AW and W go out together, each drops on its own ready
    axil_o.aw_valid = (state_q == AX_WRITE) && !aw_done_q;
    axil_o.aw_addr  = req_q.addr;
    axil_o.w_valid  = (state_q == AX_WRITE) && !w_done_q;
    axil_o.w_data   = req_q.wdata;
    axil_o.w_strb   = req_q.wstrb;
    axil_o.b_ready  = (state_q == AX_WRITE) || (state_q == AX_RESP);
    axil_o.ar_valid = (state_q == AX_READ) && !ar_done_q;
    axil_o.ar_addr  = req_q.addr;
    axil_o.r_ready  = (state_q == AX_READ);
  end

  assign aw_hs = axil_o.aw_valid && axil_i.aw_ready;
  assign w_hs  = axil_o.w_valid && axil_i.w_ready;
  assign b_hs  = (state_q == AX_RESP) && axil_i.b_valid;
  assign ar_hs = axil_o.ar_valid && axil_i.ar_ready;
  assign r_hs  = axil_o.r_ready && axil_i.r_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= AX_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      ar_done_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        AX_IDLE: begin
          if (accept_o) begin
            state_q   <= (req_i.op == OP_WRITE) ? AX_WRITE : AX_READ;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            ar_done_q <= 1'b0;
          end
        end
        AX_WRITE: begin
          if (aw_hs) begin
            aw_done_q <= 1'b1;
          end
          if (w_hs) begin
            w_done_q <= 1'b1;
          end
          if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
            state_q <= AX_RESP;
          end
        end
        AX_RESP: begin
          if (b_hs) begin
            state_q <= AX_IDLE;
            done_q  <= 1'b1;
          end
        end
        AX_READ: begin
          if (ar_hs) begin
            ar_done_q <= 1'b1;
          end
          if (r_hs) begin
            state_q <= AX_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: begin
          state_q <= AX_IDLE;
        end
      endcase
    end
  end

  // Any nonzero response code is an error
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      req_q <= req_i;
    end
    if (b_hs) begin
      rsp_q.rdata <= '0;
      rsp_q.err   <= |axil_i.b_resp;
    end else if (r_hs) begin
      rsp_q.rdata <= axil_i.r_data;
      rsp_q.err   <= |axil_i.r_resp;
    end
  end

endmodule

/* source/mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Core load port
  input  logic                      ld_req_valid_i,
  output logic                      ld_req_ready_o,
  input  mem_subsys_pkg::mem_req_t  ld_req_i,
  output logic                      ld_rsp_valid_o,
  output mem_subsys_pkg::mem_rsp_t  ld_rsp_o,
  // Core store port
  input  logic                      st_req_valid_i,
  output logic                      st_req_ready_o,
  input  mem_subsys_pkg::mem_req_t  st_req_i,
  output logic                      st_rsp_valid_o,
  output mem_subsys_pkg::mem_rsp_t  st_rsp_o,
  // Prefetcher control
  input  logic                      pf_cfg_set_i,
  input  mem_subsys_pkg::pf_cfg_t   pf_cfg_i,
  output mem_subsys_pkg::pf_cfg_t   pf_cfg_o,
  output logic                      pf_busy_o,
  output logic [7:0]                pf_issued_o,
  // Memory
  output mem_subsys_pkg::axil_req_t axil_o,
  input  mem_subsys_pkg::axil_rsp_t axil_i
);

  import mem_subsys_pkg::*;

  logic     ld_valid, st_valid, pf_valid;
  logic     ld_grant, st_grant, pf_grant;
  logic     ld_rsp_valid, st_rsp_valid, pf_rsp_valid;
  mem_req_t ld_req, st_req, pf_req;
  mem_rsp_t arb_rsp;
  logic     mst_valid, mst_accept, mst_done;
  mem_req_t mst_req;
  mem_rsp_t mst_rsp;

  core_port_adapter u_ld_port (
    .clk_i, .rst_ni,
    .req_valid_i(ld_req_valid_i), .req_ready_o(ld_req_ready_o), .req_i(ld_req_i),
    .rsp_valid_o(ld_rsp_valid_o), .rsp_o(ld_rsp_o),
    .arb_valid_o(ld_valid), .arb_req_o(ld_req), .arb_grant_i(ld_grant),
    .arb_rsp_valid_i(ld_rsp_valid), .arb_rsp_i(arb_rsp)
  );

  core_port_adapter u_st_port (
    .clk_i, .rst_ni,
    .req_valid_i(st_req_valid_i), .req_ready_o(st_req_ready_o), .req_i(st_req_i),
    .rsp_valid_o(st_rsp_valid_o), .rsp_o(st_rsp_o),
    .arb_valid_o(st_valid), .arb_req_o(st_req), .arb_grant_i(st_grant),
    .arb_rsp_valid_i(st_rsp_valid), .arb_rsp_i(arb_rsp)
  );

  // Snoops granted loads on the load port
  stride_prefetcher u_pf (
    .clk_i, .rst_ni,
    .cfg_set_i(pf_cfg_set_i), .cfg_i(pf_cfg_i), .cfg_o(pf_cfg_o),
    .snoop_valid_i(ld_grant), .snoop_addr_i(ld_req.addr),
    .arb_valid_o(pf_valid), .arb_req_o(pf_req), .arb_grant_i(pf_grant),
    .arb_rsp_valid_i(pf_rsp_valid), .busy_o(pf_busy_o), .issued_o(pf_issued_o)
  );

  req_arbiter u_arb (
    .clk_i, .rst_ni,
    .src_valid_i({pf_valid, st_valid, ld_valid}),
    .src_req_i({pf_req, st_req, ld_req}),
    .src_grant_o({pf_grant, st_grant, ld_grant}),
    .src_rsp_valid_o({pf_rsp_valid, st_rsp_valid, ld_rsp_valid}),
    .src_rsp_o(arb_rsp),
    .mst_valid_o(mst_valid), .mst_req_o(mst_req), .mst_accept_i(mst_accept),
    .mst_done_i(mst_done), .mst_rsp_i(mst_rsp)
  );

  axil_master u_axil (
    .clk_i, .rst_ni,
    .req_valid_i(mst_valid), .req_i(mst_req), .accept_o(mst_accept),
    .done_o(mst_done), .rsp_o(mst_rsp),
    .axil_o(axil_o), .axil_i(axil_i)
  );

endmodule

/* testbench/mem_subsys_asserts.sv */
`timescale 1ns/1ns

module mem_subsys_asserts (
  input logic                      clk_i,
  input logic                      rst_ni,
  input mem_subsys_pkg::axil_req_t axil_req_i,
  input mem_subsys_pkg::axil_rsp_t axil_rsp_i,
  input logic                      ld_valid_i,
  input logic                      ld_ready_i,
  input logic                      ld_rsp_valid_i,
  input logic                      st_valid_i,
  input logic                      st_ready_i,
  input logic                      st_rsp_valid_i
);

  int   assert_fails = 0;
  logic ld_pend_q;
  logic st_pend_q;

  // Outstanding request per core port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_pend_q <= 1'b0;
      st_pend_q <= 1'b0;
    end else begin
      if (ld_valid_i && ld_ready_i) begin
        ld_pend_q <= 1'b1;
      end else if (ld_rsp_valid_i) begin
        ld_pend_q <= 1'b0;
      end
      if (st_valid_i && st_ready_i) begin
        st_pend_q <= 1'b1;
      end else if (st_rsp_valid_i) begin
        st_pend_q <= 1'b0;
      end
    end
  end

  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_req_i.aw_valid && !axil_rsp_i.aw_ready |=> axil_req_i.aw_valid)
    else begin
      $error("aw_valid dropped before aw_ready");
      assert_fails++;
    end

  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_req_i.w_valid && !axil_rsp_i.w_ready |=> axil_req_i.w_valid)
    else begin
      $error("w_valid dropped before w_ready");
      assert_fails++;
    end

  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_req_i.ar_valid && !axil_rsp_i.ar_ready |=> axil_req_i.ar_valid)
    else begin
      $error("ar_valid dropped before ar_ready");
      assert_fails++;
    end

  // Write and read address never together
  a_aw_ar_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(axil_req_i.aw_valid && axil_req_i.ar_valid))
    else begin
      $error("aw_valid and ar_valid high together");
      assert_fails++;
    end

  a_ld_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ld_rsp_valid_i |-> ld_pend_q)
    else begin
      $error("load response without an accepted request");
      assert_fails++;
    end

  a_st_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    st_rsp_valid_i |-> st_pend_q)
    else begin
      $error("store response without an accepted request");
      assert_fails++;
    end

endmodule

bind mem_subsys_top mem_subsys_asserts u_asserts (
  .clk_i(clk_i),
  .rst_ni(rst_ni),
  .axil_req_i(axil_o),
  .axil_rsp_i(axil_i),
  .ld_valid_i(ld_req_valid_i),
  .ld_ready_i(ld_req_ready_o),
  .ld_rsp_valid_i(ld_rsp_valid_o),
  .st_valid_i(st_req_valid_i),
  .st_ready_i(st_req_ready_o),
  .st_rsp_valid_i(st_rsp_valid_o)
);

/* testbench/tb_mem_subsys.sv */
`timescale 1ns/1ns

module tb_mem_subsys;

  import mem_subsys_pkg::*;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      ld_req_valid_i;
  logic      ld_req_ready_o;
  mem_req_t  ld_req_i;
  logic      ld_rsp_valid_o;
  mem_rsp_t  ld_rsp_o;
  logic      st_req_valid_i;
  logic      st_req_ready_o;
  mem_req_t  st_req_i;
  logic      st_rsp_valid_o;
  mem_rsp_t  st_rsp_o;
  logic      pf_cfg_set_i;
  pf_cfg_t   pf_cfg_i;
  pf_cfg_t   pf_cfg_o;
  logic      pf_busy_o;
  logic [7:0] pf_issued_o;
  axil_req_t axil_o;
  axil_rsp_t axil_i;

  // Test vectors, one entry per data line
  byte         t_kind[$];
  logic [31:0] t_addr[$];
  logic [31:0] t_wdat[$];
  logic [31:0] t_strb[$];
  logic [31:0] t_rdat[$];
  logic        t_err[$];
  int          n_tests = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          err_cnt = 0;

  // Response capture
  int       ld_rsp_n = 0;
  int       st_rsp_n = 0;
  int       ld_exp = 0;
  int       st_exp = 0;
  mem_rsp_t ld_rsp_s;
  mem_rsp_t st_rsp_s;

  // Prefetcher setup as last programmed
  logic        pf_armed = 1'b0;
  logic [31:0] pf_base;
  logic [31:0] pf_stride;
  int          pf_cnt;

  // Memory model state
  logic [31:0] mem_model [logic [29:0]];
  logic [31:0] lfsr = 32'ha3f987c9;
  logic [31:0] ar_log[$];
  axil_req_t   ax_s;
  logic        have_aw, have_w, have_ar;
  int          aw_cnt, w_cnt, ar_cnt;
  logic [31:0] wr_addr, wr_data, rd_addr;
  logic [3:0]  wr_strb;

  mem_subsys_top dut0 (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .ld_req_valid_i(ld_req_valid_i), .ld_req_ready_o(ld_req_ready_o), .ld_req_i(ld_req_i),
    .ld_rsp_valid_o(ld_rsp_valid_o), .ld_rsp_o(ld_rsp_o),
    .st_req_valid_i(st_req_valid_i), .st_req_ready_o(st_req_ready_o), .st_req_i(st_req_i),
    .st_rsp_valid_o(st_rsp_valid_o), .st_rsp_o(st_rsp_o),
    .pf_cfg_set_i(pf_cfg_set_i), .pf_cfg_i(pf_cfg_i), .pf_cfg_o(pf_cfg_o),
    .pf_busy_o(pf_busy_o), .pf_issued_o(pf_issued_o),
    .axil_o(axil_o), .axil_i(axil_i)
  );

  always #10 clk_i = ~clk_i;

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  // Unwritten words hold a pattern of their own address
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem_model.exists(addr[31:2])) begin
      return mem_model[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
  endfunction

  function automatic void write_word(input logic [31:0] addr, input logic [31:0] data,
                                     input logic [3:0] strb);
    logic [31:0] w;
    w = read_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = data[8*b +: 8];
      end
    end
    mem_model[addr[31:2]] = w;
  endfunction

  // Ready after 0 to 3 cycles
  task automatic step_wait(inout int cnt, output logic go);
    if (cnt < 0) begin
      cnt = rand_bits(2);
    end
    go = (cnt == 0);
    cnt = (cnt == 0) ? -1 : cnt - 1;
  endtask

  always @(negedge clk_i) begin : axil_slave
    if (!rst_ni) begin
      axil_i  = '0;
      have_aw = 1'b0;
      have_w  = 1'b0;
      have_ar = 1'b0;
      aw_cnt  = -1;
      w_cnt   = -1;
      ar_cnt  = -1;
    end else begin
      // Handshakes taken at the last rising edge
      if (axil_i.aw_ready && ax_s.aw_valid) begin
        axil_i.aw_ready = 1'b0;
        have_aw = 1'b1;
        wr_addr = ax_s.aw_addr;
      end
      if (axil_i.w_ready && ax_s.w_valid) begin
        axil_i.w_ready = 1'b0;
        have_w  = 1'b1;
        wr_data = ax_s.w_data;
        wr_strb = ax_s.w_strb;
      end
      if (axil_i.ar_ready && ax_s.ar_valid) begin
        axil_i.ar_ready = 1'b0;
        have_ar = 1'b1;
        rd_addr = ax_s.ar_addr;
        ar_log.push_back(ax_s.ar_addr);
      end
      if (axil_i.b_valid && ax_s.b_ready) begin
        axil_i.b_valid = 1'b0;
      end
      if (axil_i.r_valid && ax_s.r_ready) begin
        axil_i.r_valid = 1'b0;
      end
      if (axil_o.aw_valid && !axil_i.aw_ready && !have_aw) begin
        step_wait(aw_cnt, axil_i.aw_ready);
      end
      if (axil_o.w_valid && !axil_i.w_ready && !have_w) begin
        step_wait(w_cnt, axil_i.w_ready);
      end
      if (axil_o.ar_valid && !axil_i.ar_ready && !have_ar) begin
        step_wait(ar_cnt, axil_i.ar_ready);
      end
      // Bit 15 marks the error window
      if (have_aw && have_w && !axil_i.b_valid) begin
        have_aw = 1'b0;
        have_w  = 1'b0;
        axil_i.b_resp = wr_addr[15] ? 2'b10 : 2'b00;
        if (!wr_addr[15]) begin
          write_word(wr_addr, wr_data, wr_strb);
        end
        axil_i.b_valid = 1'b1;
      end
      if (have_ar && !axil_i.r_valid) begin
        have_ar = 1'b0;
        axil_i.r_resp  = rd_addr[15] ? 2'b10 : 2'b00;
        axil_i.r_data  = rd_addr[15] ? 32'h0 : read_word(rd_addr);
        axil_i.r_valid = 1'b1;
      end
    end
    ax_s = axil_o;
  end

  // Response pulses are stable at the falling edge
  always @(negedge clk_i) begin : rsp_capture
    if (ld_rsp_valid_o) begin
      ld_rsp_n++;
      ld_rsp_s = ld_rsp_o;
    end
    if (st_rsp_valid_o) begin
      st_rsp_n++;
      st_rsp_s = st_rsp_o;
    end
  end

  task automatic read_tests();
    int fd;
    int c;
    int r;
    logic [31:0] a, d, s, x, e;
    fd = $fopen("testbench/mem_subsys_tests.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open testbench/mem_subsys_tests.txt");
      err_cnt++;
      return;
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (c == "L" || c == "S" || c == "P") begin
        r = $fscanf(fd, "%h %h %h %h %h", a, d, s, x, e);
        if (r == 5) begin
          t_kind.push_back(c[7:0]);
          t_addr.push_back(a);
          t_wdat.push_back(d);
          t_strb.push_back(s);
          t_rdat.push_back(x);
          t_err.push_back(e[0]);
        end else begin
          $display("error: test line %0d is malformed", t_kind.size() + 1);
          err_cnt++;
        end
      end
      if (c != -1) begin
        c = $fgetc(fd);
      end
    end
    $fclose(fd);
    n_tests = t_kind.size();
  endtask

  task automatic report_test(input int idx, input logic ok);
    $display("test %0d: %c %h %s", idx + 1, t_kind[idx], t_addr[idx], ok ? "ok" : "error");
    if (ok) begin
      n_pass++;
    end else begin
      n_fail++;
    end
  endtask

  task automatic send_req(input logic is_st, input mem_req_t req);
    if (is_st) begin
      while (!st_req_ready_o) @(negedge clk_i);
      st_req_valid_i = 1'b1;
      st_req_i       = req;
      @(negedge clk_i);
      st_req_valid_i = 1'b0;
      if (st_req_ready_o) begin
        $display("error at %0t: store port ready while its request is outstanding", $time);
        err_cnt++;
      end
    end else begin
      while (!ld_req_ready_o) @(negedge clk_i);
      ld_req_valid_i = 1'b1;
      ld_req_i       = req;
      @(negedge clk_i);
      ld_req_valid_i = 1'b0;
      if (ld_req_ready_o) begin
        $display("error at %0t: load port ready while its request is outstanding", $time);
        err_cnt++;
      end
    end
  endtask

  task automatic check_rsp(input int idx, input mem_rsp_t rsp, input int n_got,
                           input int n_want);
    if (n_got != n_want) begin
      $display("mismatch at %0t: test %0d port gave %0d responses, expected %0d",
               $time, idx + 1, n_got, n_want);
      err_cnt++;
    end
    if (rsp.err !== t_err[idx]) begin
      $display("mismatch at %0t: test %0d err %b, expected %b",
               $time, idx + 1, rsp.err, t_err[idx]);
      err_cnt++;
    end
    if (t_kind[idx] == "L" && !t_err[idx] && rsp.rdata !== t_rdat[idx]) begin
      $display("mismatch at %0t: test %0d rdata %h, expected %h",
               $time, idx + 1, rsp.rdata, t_rdat[idx]);
      err_cnt++;
    end
  endtask

  // A store with a load right behind it runs both ports at once
  task automatic run_mem(input int idx, input logic paired);
    int         st_idx;
    int         ld_idx;
    int         n_pf;
    int         e0;
    int         st_errs;
    int         ld_errs;
    logic [7:0] iss0;
    mem_req_t   req;
    st_idx  = (t_kind[idx] == "S") ? idx : -1;
    ld_idx  = paired ? idx + 1 : ((t_kind[idx] == "L") ? idx : -1);
    st_errs = 0;
    ld_errs = 0;
    ar_log.delete();
    iss0 = pf_issued_o;
    if (st_idx >= 0) begin
      req = '{op: OP_WRITE, addr: t_addr[st_idx], wdata: t_wdat[st_idx],
              wstrb: t_strb[st_idx][3:0]};
      st_exp++;
      e0 = err_cnt;
      send_req(1'b1, req);
      st_errs += err_cnt - e0;
    end
    if (ld_idx >= 0) begin
      req = '{op: OP_READ, addr: t_addr[ld_idx], wdata: 32'h0, wstrb: 4'h0};
      ld_exp++;
      e0 = err_cnt;
      send_req(1'b0, req);
      ld_errs += err_cnt - e0;
    end
    while (ld_rsp_n < ld_exp || st_rsp_n < st_exp) @(negedge clk_i);
    while (pf_busy_o) @(negedge clk_i);
    if (st_idx >= 0) begin
      e0 = err_cnt;
      check_rsp(st_idx, st_rsp_s, st_rsp_n, st_exp);
      report_test(st_idx, (st_errs + err_cnt - e0) == 0);
    end
    if (ld_idx >= 0) begin
      e0 = err_cnt;
      check_rsp(ld_idx, ld_rsp_s, ld_rsp_n, ld_exp);
      n_pf = (pf_armed && t_addr[ld_idx] == pf_base) ? pf_cnt : 0;
      if (ar_log.size() != n_pf + 1) begin
        $display("mismatch at %0t: test %0d saw %0d AR addresses, expected %0d",
                 $time, ld_idx + 1, ar_log.size(), n_pf + 1);
        err_cnt++;
      end else begin
        if (ar_log[0] !== t_addr[ld_idx]) begin
          $display("mismatch at %0t: test %0d load AR address %h, expected %h",
                   $time, ld_idx + 1, ar_log[0], t_addr[ld_idx]);
          err_cnt++;
        end
        for (int k = 1; k <= n_pf; k++) begin
          if (ar_log[k] !== pf_base + k * pf_stride) begin
            $display("mismatch at %0t: test %0d prefetch %0d address %h, expected %h",
                     $time, ld_idx + 1, k, ar_log[k], pf_base + k * pf_stride);
            err_cnt++;
          end
        end
      end
      if (pf_issued_o !== 8'(iss0 + n_pf)) begin
        $display("mismatch at %0t: test %0d pf_issued %0d, expected %0d",
                 $time, ld_idx + 1, pf_issued_o, 8'(iss0 + n_pf));
        err_cnt++;
      end
      report_test(ld_idx, (ld_errs + err_cnt - e0) == 0);
    end
  endtask

  task automatic run_cfg(input int idx);
    pf_cfg_t cfg;
    int      e0;
    e0  = err_cnt;
    cfg = '{base: t_addr[idx], stride: t_wdat[idx], count: t_strb[idx][3:0]};
    pf_cfg_i     = cfg;
    pf_cfg_set_i = 1'b1;
    @(negedge clk_i);
    pf_cfg_set_i = 1'b0;
    if (pf_cfg_o !== cfg) begin
      $display("mismatch at %0t: test %0d pf_cfg_o %h, expected %h",
               $time, idx + 1, pf_cfg_o, cfg);
      err_cnt++;
    end
    pf_armed  = 1'b1;
    pf_base   = t_addr[idx];
    pf_stride = t_wdat[idx];
    pf_cnt    = t_strb[idx][3:0];
    report_test(idx, err_cnt == e0);
  endtask

  initial begin : main
    int i;
    rst_ni         = 1'b0;
    ld_req_valid_i = 1'b0;
    ld_req_i       = '0;
    st_req_valid_i = 1'b0;
    st_req_i       = '0;
    pf_cfg_set_i   = 1'b0;
    pf_cfg_i       = '0;
    axil_i         = '0;
    read_tests();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (axil_o.aw_valid || axil_o.w_valid || axil_o.ar_valid || ld_rsp_valid_o ||
        st_rsp_valid_o || pf_busy_o || pf_issued_o != 8'd0 || !ld_req_ready_o ||
        !st_req_ready_o) begin
      $display("error at %0t: outputs not in their idle state after reset", $time);
      err_cnt++;
    end
    if (n_tests == 0) begin
      $display("error: no test vectors were read");
      err_cnt++;
    end
    i = 0;
    while (i < n_tests) begin
      if (t_kind[i] == "P") begin
        run_cfg(i);
        i++;
      end else if (t_kind[i] == "S" && i + 1 < n_tests && t_kind[i + 1] == "L") begin
        run_mem(i, 1'b1);
        i += 2;
      end else begin
        run_mem(i, 1'b0);
        i++;
      end
    end
    if (dut0.u_asserts.assert_fails != 0) begin
      $display("error: %0d assertion failures on the DUT", dut0.u_asserts.assert_fails);
      err_cnt += dut0.u_asserts.assert_fails;
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             n_tests, n_pass, n_fail, err_cnt);
    if (err_cnt == 0 && n_fail == 0 && n_tests > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    wait (n_tests > 0);
    repeat (n_tests * 200) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", n_tests * 200);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* testbench/mem_subsys_tests.txt */
# kind addr_or_base wdata_or_stride wstrb_or_count exp_rdata exp_err (hex)
# S rdata not compared, an L right after an S is issued on the other port at once
L 00001000 00000000 0 5a5a1000 0
L 00002004 00000000 0 5a5a2004 0
S 00003000 11223344 f 00000000 0
L 00003000 00000000 0 11223344 0
S 00003000 aabbccdd 3 00000000 0
L 00003000 00000000 0 1122ccdd 0
S 00004000 deadbeef 4 00000000 0
L 00004000 00000000 0 5aad4000 0
L 00008010 00000000 0 00000000 1
S 00008020 12345678 f 00000000 1
L 00008020 00000000 0 00000000 1
S 00005000 cafef00d f 00000000 0
L 00001000 00000000 0 5a5a1000 0
L 00005000 00000000 0 cafef00d 0
P 00006000 00000040 3 00000000 0
L 00006000 00000000 0 5a5a6000 0
L 00006100 00000000 0 5a5a6100 0
L 00006000 00000000 0 5a5a6000 0
P 00007000 00000100 2 00000000 0
L 00007000 00000000 0 5a5a7000 0
S 00007200 0000beef 3 00000000 0
L 00006000 00000000 0 5a5a6000 0

/* project.f */
+incdir+source
source/mem_subsys_pkg.sv
source/core_port_adapter.sv
source/stride_prefetcher.sv
source/req_arbiter.sv
source/axil_master.sv
source/mem_subsys_top.sv
testbench/mem_subsys_asserts.sv
testbench/tb_mem_subsys.sv
